// ==== src/isa_pkg.sv ====
// Instruction set of the 16-bit core.
// The opcode sits in bits 15:12. Codes 4'hC to 4'hF are illegal.
// Branch and jump offsets count words relative to PC+2.
package isa_pkg;

   localparam int WORD_W = 16;
   localparam int OPC_W  = 4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [2:0]        reg_idx_t;

   typedef enum logic [OPC_W-1:0] {
      OP_HALT = 4'h0,
      OP_NOP  = 4'h1,
      OP_ADD  = 4'h2,
      OP_SUB  = 4'h3,
      OP_AND  = 4'h4,
      OP_XOR  = 4'h5,
      OP_ADDI = 4'h6,
      OP_LBI  = 4'h7,
      OP_LD   = 4'h8,
      OP_ST   = 4'h9,
      OP_BEQZ = 4'hA,
      OP_J    = 4'hB
   } opcode_e;

   // field positions
   localparam int OPC_MSB   = 15;
   localparam int RD_MSB    = 11;
   localparam int RD_LSB    = 9;
   localparam int RS_MSB    = 8;
   localparam int RS_LSB    = 6;
   localparam int RT_MSB    = 5;
   localparam int RT_LSB    = 3;
   localparam int IMM6_MSB  = 5;
   localparam int IMM9_MSB  = 8;
   localparam int IMM12_MSB = 11;

   // R-type      op rd rs rt
   // ADDI LD ST  op rd rs imm6, rd holds the store data
   // LBI BEQZ    op rd imm9
   // J           op imm12
   localparam word_t NOP_WORD = {OP_NOP, 12'h000};

endpackage

// ==== src/pipe_pkg.sv ====
// Microarchitecture constants of the four-stage pipeline.
// The data memory is word addressed through address bits 8:1.
package pipe_pkg;

   import isa_pkg::*;

   // result source of the instruction in execute
   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1
   } wb_sel_e;

   // operand source in execute
   typedef enum logic {
      FWD_REG  = 1'b0,
      FWD_EXWB = 1'b1
   } fwd_sel_e;

   localparam word_t RESET_PC   = 16'h0000;
   localparam int    DMEM_WORDS = 256;
   localparam int    DMEM_AW    = $clog2(DMEM_WORDS);

endpackage

// ==== src/fetch.sv ====
// Program counter of the fetch stage.
// The instruction word comes back combinationally from outside the core.
module fetch import isa_pkg::*, pipe_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  stall,
   input  logic  flush,
   input  word_t redirect_pc,
   output word_t imem_addr,
   output word_t pc_plus_two
);

   word_t pc;

   assign imem_addr   = pc;
   assign pc_plus_two = pc + 16'd2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= RESET_PC;
      end else if (flush) begin
         // taken branch or jump in execute
         pc <= redirect_pc;
      end else if (!stall) begin
         pc <= pc_plus_two;
      end
   end

   // execute never redirects once it has halted
   a_flush_not_stall: assert property (
      @(posedge clk) disable iff (!rst_n) !(flush && stall)
   );

endmodule

// ==== src/pipe_regs.sv ====
// IF/ID, ID/EX and EX/WB registers.
// Flush turns IF/ID and ID/EX into bubbles. Stall holds all three,
// and EX/WB retires nothing while stalled.
module pipe_regs import isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     stall,
   input  logic     flush,
   input  word_t    if_instr,
   input  word_t    if_pc2,
   input  reg_idx_t id_rd,
   input  reg_idx_t id_rs,
   input  reg_idx_t id_rt,
   input  word_t    id_a,
   input  word_t    id_b,
   input  word_t    id_imm,
   input  opcode_e  id_op,
   input  logic     id_wb_en,
   input  word_t    ex_result,
   input  logic     ex_wb_en,
   input  reg_idx_t ex_dst,
   output word_t    ifid_instr,
   output word_t    ifid_pc2,
   output reg_idx_t idex_rd,
   output reg_idx_t idex_rs,
   output reg_idx_t idex_rt,
   output word_t    idex_a,
   output word_t    idex_b,
   output word_t    idex_imm,
   output opcode_e  idex_op,
   output logic     idex_wb_en,
   output word_t    idex_pc2,
   output logic     wb_en,
   output reg_idx_t wb_dst,
   output word_t    wb_data
);

   // control part, bubbles are NOP with no write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ifid_instr <= NOP_WORD;
         idex_op    <= OP_NOP;
         idex_wb_en <= 1'b0;
         wb_en      <= 1'b0;
      end else begin
         if (flush) begin
            ifid_instr <= NOP_WORD;
            idex_op    <= OP_NOP;
            idex_wb_en <= 1'b0;
         end else if (!stall) begin
            ifid_instr <= if_instr;
            idex_op    <= id_op;
            idex_wb_en <= id_wb_en;
         end
         wb_en <= ex_wb_en && !stall;
      end
   end

   // payload part
   always_ff @(posedge clk) begin
      if (!stall) begin
         ifid_pc2 <= if_pc2;
         idex_rd  <= id_rd;
         idex_rs  <= id_rs;
         idex_rt  <= id_rt;
         idex_a   <= id_a;
         idex_b   <= id_b;
         idex_imm <= id_imm;
         idex_pc2 <= ifid_pc2;
         wb_dst   <= ex_dst;
         wb_data  <= ex_result;
      end
   end

endmodule

// ==== src/decode.sv ====
// Decode and register read. The file is written before it is read, so a
// value retiring this cycle is already visible to the instruction here.
// For ST and BEQZ the second read port reads the rd field.
module decode import isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  word_t    instr,
   input  logic     wb_en,
   input  reg_idx_t wb_dst,
   input  word_t    wb_data,
   output reg_idx_t rd,
   output reg_idx_t rs,
   output reg_idx_t rt,
   output word_t    a,
   output word_t    b,
   output word_t    imm,
   output opcode_e  op,
   output logic     wr_en,
   output logic     err
);

   word_t   rf [8];
   opcode_e raw_op;
   word_t   imm6_ext;
   word_t   imm9_ext;
   word_t   imm12_ext;

   assign raw_op    = opcode_e'(instr[OPC_MSB -: OPC_W]);
   assign rd        = instr[RD_MSB:RD_LSB];
   assign rs        = instr[RS_MSB:RS_LSB];
   assign imm6_ext  = {{(WORD_W-IMM6_MSB-1){instr[IMM6_MSB]}}, instr[IMM6_MSB:0]};
   assign imm9_ext  = {{(WORD_W-IMM9_MSB-1){instr[IMM9_MSB]}}, instr[IMM9_MSB:0]};
   assign imm12_ext = {{(WORD_W-IMM12_MSB-1){instr[IMM12_MSB]}}, instr[IMM12_MSB:0]};

   always_comb begin
      op    = raw_op;
      rt    = instr[RT_MSB:RT_LSB];
      imm   = '0;
      wr_en = 1'b0;
      err   = 1'b0;
      case (raw_op)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: wr_en = 1'b1;
         OP_ADDI, OP_LD: begin
            imm   = imm6_ext;
            wr_en = 1'b1;
         end
         OP_ST: begin
            imm = imm6_ext;
            rt  = rd;
         end
         OP_LBI: begin
            imm   = imm9_ext;
            wr_en = 1'b1;
         end
         OP_BEQZ: begin
            imm = imm9_ext;
            rt  = rd;
         end
         OP_J: imm = imm12_ext;
         OP_HALT, OP_NOP: ;
         default: begin
            // unknown code goes down the pipe as a NOP
            op  = OP_NOP;
            err = 1'b1;
         end
      endcase
   end

   // read with bypass from the retiring instruction
   assign a = (wb_en && wb_dst == rs) ? wb_data : rf[rs];
   assign b = (wb_en && wb_dst == rt) ? wb_data : rf[rt];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_en) begin
         rf[wb_dst] <= wb_data;
      end
   end

   a_legal_op: assert property (
      @(posedge clk) disable iff (!rst_n)
      op inside {OP_HALT, OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_XOR,
                 OP_ADDI, OP_LBI, OP_LD, OP_ST, OP_BEQZ, OP_J}
   );

endmodule

// ==== src/execute.sv ====
// Execute with data memory access. Branches and jumps resolve here.
// The data memory reads asynchronously and writes at the clock edge.
// After HALT the core stays halted until reset.
module execute import isa_pkg::*, pipe_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t idex_rs,
   input  reg_idx_t idex_rt,
   input  word_t    idex_a,
   input  word_t    idex_b,
   input  word_t    idex_imm,
   input  opcode_e  idex_op,
   input  logic     exwb_wb_en,
   input  reg_idx_t exwb_dst,
   input  word_t    exwb_data,
   input  word_t    pc2,
   output word_t    result,
   output logic     flush,
   output word_t    redirect_pc,
   output logic     halted,
   output logic     stall
);

   fwd_sel_e           fwd_a;
   fwd_sel_e           fwd_b;
   wb_sel_e            res_sel;
   word_t              opa;
   word_t              opb;
   word_t              alu_out;
   word_t              mem_addr;
   word_t              mem_rdata;
   logic [DMEM_AW-1:0] mem_idx;
   logic               mem_we;
   logic               taken;
   word_t              dmem [DMEM_WORDS];

   // forward from the instruction one ahead
   assign fwd_a = (exwb_wb_en && exwb_dst == idex_rs) ? FWD_EXWB : FWD_REG;
   assign fwd_b = (exwb_wb_en && exwb_dst == idex_rt) ? FWD_EXWB : FWD_REG;
   assign opa   = (fwd_a == FWD_EXWB) ? exwb_data : idex_a;
   assign opb   = (fwd_b == FWD_EXWB) ? exwb_data : idex_b;

   // base plus offset for ADDI, LD and ST
   assign mem_addr = opa + idex_imm;

   always_comb begin
      case (idex_op)
         OP_ADD:                alu_out = opa + opb;
         OP_SUB:                alu_out = opa - opb;
         OP_AND:                alu_out = opa & opb;
         OP_XOR:                alu_out = opa ^ opb;
         OP_ADDI, OP_LD, OP_ST: alu_out = mem_addr;
         OP_LBI:                alu_out = idex_imm;
         default:               alu_out = '0;
      endcase
   end

   assign mem_idx   = mem_addr[DMEM_AW:1];
   assign mem_rdata = dmem[mem_idx];
   assign mem_we    = (idex_op == OP_ST) && !halted;
   assign res_sel   = (idex_op == OP_LD) ? WB_MEM : WB_ALU;
   assign result    = (res_sel == WB_MEM) ? mem_rdata : alu_out;

   // the data memory starts from zero after every reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (mem_we) begin
         dmem[mem_idx] <= opb;
      end
   end

   // BEQZ tests the register read through the second port
   assign taken       = (idex_op == OP_J) || (idex_op == OP_BEQZ && opb == '0);
   assign flush       = taken && !halted;
   assign redirect_pc = pc2 + {idex_imm[WORD_W-2:0], 1'b0};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (idex_op == OP_HALT) begin
         halted <= 1'b1;
      end
   end

   assign stall = halted;

   a_no_write_halted: assert property (
      @(posedge clk) disable iff (!rst_n) halted |-> !mem_we
   );

endmodule

// ==== src/proc.sv ====
// Top level of the four-stage core: fetch, decode, execute, writeback.
// Instruction memory sits outside and answers imem_addr in the same cycle.
module proc import isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  word_t    imem_data,
   output word_t    imem_addr,
   output logic     wb_en,
   output reg_idx_t wb_dst,
   output word_t    wb_data,
   output logic     halted,
   output logic     err
);

   logic     stall;
   logic     flush;
   word_t    redirect_pc;
   word_t    pc_plus_two;
   word_t    ifid_instr;
   word_t    ifid_pc2;
   reg_idx_t id_rd;
   reg_idx_t id_rs;
   reg_idx_t id_rt;
   word_t    id_a;
   word_t    id_b;
   word_t    id_imm;
   opcode_e  id_op;
   logic     id_wb_en;
   reg_idx_t idex_rd;
   reg_idx_t idex_rs;
   reg_idx_t idex_rt;
   word_t    idex_a;
   word_t    idex_b;
   word_t    idex_imm;
   opcode_e  idex_op;
   logic     idex_wb_en;
   word_t    idex_pc2;
   word_t    ex_result;

   fetch fetch0 (
      .clk, .rst_n, .stall, .flush, .redirect_pc,
      .imem_addr, .pc_plus_two
   );

   pipe_regs regs0 (
      .clk, .rst_n, .stall, .flush,
      .if_instr(imem_data), .if_pc2(pc_plus_two),
      .id_rd, .id_rs, .id_rt, .id_a, .id_b, .id_imm, .id_op, .id_wb_en,
      // destination and write enable pass straight through execute
      .ex_result, .ex_wb_en(idex_wb_en), .ex_dst(idex_rd),
      .ifid_instr, .ifid_pc2,
      .idex_rd, .idex_rs, .idex_rt, .idex_a, .idex_b, .idex_imm,
      .idex_op, .idex_wb_en, .idex_pc2,
      .wb_en, .wb_dst, .wb_data
   );

   decode decode0 (
      .clk, .rst_n, .instr(ifid_instr),
      .wb_en, .wb_dst, .wb_data,
      .rd(id_rd), .rs(id_rs), .rt(id_rt), .a(id_a), .b(id_b),
      .imm(id_imm), .op(id_op), .wr_en(id_wb_en), .err
   );

   execute execute0 (
      .clk, .rst_n,
      .idex_rs, .idex_rt, .idex_a, .idex_b, .idex_imm, .idex_op,
      .exwb_wb_en(wb_en), .exwb_dst(wb_dst), .exwb_data(wb_data),
      .pc2(idex_pc2),
      .result(ex_result), .flush, .redirect_pc, .halted, .stall
   );

endmodule

// ==== testbench/tb_clock.sv ====
// Free-running clock for the testbench, starts low.
module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== testbench/proc_tb.sv ====
// Directed tests of the core against a reference interpreter of the ISA.
// Programs sit in a 256-word array indexed by imem_addr[8:1], unused words
// read as NOP. Every test resets the core, so data memory starts at zero.
module proc_tb import isa_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 8;
   localparam int CYCLES_PER_WORD = 40;
   localparam int DRIVE_DELAY     = 1;

   logic     clk;
   logic     rst_n;
   word_t    imem_data;
   word_t    imem_addr;
   logic     wb_en;
   reg_idx_t wb_dst;
   word_t    wb_data;
   logic     halted;
   logic     err;

   word_t    prog [256];
   int       prog_len;
   int       seed = 32'h1a638de4;
   reg_idx_t exp_dst [$];
   word_t    exp_val [$];
   logic     exp_err;
   word_t    exp_halt_pc;
   logic     monitor_on = 1'b0;
   time      budget = 64'(16 * CLK_PERIOD);

   // owned by the retire monitor
   int retires = 0;
   int retire_base = 0;
   int wb_mismatches = 0;
   int extra_retires = 0;
   int err_cycles = 0;
   // owned by the main sequence
   int flag_mismatches = 0;
   int addr_mismatches = 0;
   int tests_run = 0;
   int tests_failed = 0;

   tb_clock #(.PERIOD(CLK_PERIOD)) clk_gen (.clk);

   proc dut (
      .clk, .rst_n, .imem_data, .imem_addr,
      .wb_en, .wb_dst, .wb_data, .halted, .err
   );

   // instruction memory answers in the same cycle
   assign imem_data = prog[imem_addr[8:1]];

   function automatic word_t enc_r(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic word_t enc_i6(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic word_t enc_i9(opcode_e op, reg_idx_t rd, logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic word_t enc_j(logic [11:0] off);
      return {OP_J, off};
   endfunction

   task automatic clear_program();
      prog = '{default: NOP_WORD};
      prog_len = 0;
   endtask

   task automatic emit(word_t w);
      prog[8'(prog_len)] = w;
      prog_len++;
   endtask

   task automatic emit_lbi_random(reg_idx_t rd);
      int r;
      r = $random(seed);
      emit(enc_i9(OP_LBI, rd, r[8:0]));
   endtask

   // runs the program by the ISA rules and lists the expected retires
   task automatic interpret();
      word_t      regs [8];
      word_t      mem [256];
      word_t      pc;
      word_t      pc2;
      word_t      w;
      word_t      val;
      word_t      addr;
      word_t      i6;
      word_t      i9;
      word_t      i12;
      logic [3:0] opc;
      reg_idx_t   rd;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic       wr;
      logic       done;
      int         steps;
      regs = '{default: 16'h0000};
      mem = '{default: 16'h0000};
      exp_dst.delete();
      exp_val.delete();
      exp_err = 1'b0;
      exp_halt_pc = 16'h0000;
      pc = 16'h0000;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         w = prog[pc[8:1]];
         opc = w[15:12];
         rd = w[11:9];
         rs = w[8:6];
         rt = w[5:3];
         i6 = {{10{w[5]}}, w[5:0]};
         i9 = {{7{w[8]}}, w[8:0]};
         i12 = {{4{w[11]}}, w[11:0]};
         pc2 = pc + 16'd2;
         pc = pc2;
         addr = regs[rs] + i6;
         wr = 1'b0;
         val = 16'h0000;
         steps++;
         case (opc)
            OP_HALT: begin
               done = 1'b1;
               // fetch is three words past HALT once the stall holds it
               exp_halt_pc = pc2 + 16'd4;
            end
            OP_NOP: ;
            OP_ADD: {wr, val} = {1'b1, regs[rs] + regs[rt]};
            OP_SUB: {wr, val} = {1'b1, regs[rs] - regs[rt]};
            OP_AND: {wr, val} = {1'b1, regs[rs] & regs[rt]};
            OP_XOR: {wr, val} = {1'b1, regs[rs] ^ regs[rt]};
            OP_ADDI: {wr, val} = {1'b1, addr};
            OP_LBI: {wr, val} = {1'b1, i9};
            OP_LD: {wr, val} = {1'b1, mem[addr[8:1]]};
            OP_ST: mem[addr[8:1]] = regs[rd];
            OP_BEQZ: begin
               if (regs[rd] == 16'h0000) begin
                  pc = pc2 + (i9 << 1);
               end
            end
            OP_J: pc = pc2 + (i12 << 1);
            default: exp_err = 1'b1;
         endcase
         if (wr) begin
            regs[rd] = val;
            exp_dst.push_back(rd);
            exp_val.push_back(val);
         end
      end
   endtask

   task automatic check_wb(reg_idx_t got_dst, word_t got_val, reg_idx_t want_dst,
                           word_t want_val);
      if (got_dst !== want_dst || got_val !== want_val) begin
         $display("** Error at %0d ns: retire r%0d = %h, expected r%0d = %h",
                  $time, got_dst, got_val, want_dst, want_val);
         wb_mismatches++;
      end
   endtask

   task automatic check_flag(string name, logic got, logic want);
      if (got !== want) begin
         $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, want);
         flag_mismatches++;
      end
   endtask

   task automatic check_addr(string name, word_t got, word_t want);
      if (got !== want) begin
         $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
         addr_mismatches++;
      end
   endtask

   // retire monitor in program order against the interpreter
   always @(negedge clk) begin
      if (monitor_on && err) begin
         err_cycles++;
      end
      if (monitor_on && wb_en) begin
         if (retires - retire_base >= exp_dst.size()) begin
            $display("unexpected retire of r%0d = %h at %0d ns, reference has no more results",
                     wb_dst, wb_data, $time);
            extra_retires++;
         end else begin
            check_wb(wb_dst, wb_data, exp_dst[retires - retire_base],
                     exp_val[retires - retire_base]);
         end
         retires++;
      end
   end

   // resets the core, runs to HALT and keeps clocking for hold cycles
   task automatic run_program(string name, int hold);
      int limit;
      int cycles;
      int fails;
      int wb_base;
      int extra_base;
      int err_base;
      int flag_base;
      int addr_base;
      interpret();
      limit = CYCLES_PER_WORD * prog_len;
      budget += 64'((limit + RESET_CYCLES + hold + 8) * CLK_PERIOD);
      fails = 0;
      wb_base = wb_mismatches;
      extra_base = extra_retires;
      err_base = err_cycles;
      flag_base = flag_mismatches;
      addr_base = addr_mismatches;
      @(posedge clk);
      #DRIVE_DELAY rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      check_flag("wb_en in reset", wb_en, 1'b0);
      check_flag("halted in reset", halted, 1'b0);
      check_flag("err in reset", err, 1'b0);
      check_addr("imem_addr in reset", imem_addr, 16'h0000);
      retire_base = retires;
      monitor_on = 1'b1;
      rst_n = 1'b1;
      cycles = 0;
      while (!halted && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("%s: the core did not halt within %0d cycles", name, limit);
         fails++;
      end
      repeat (hold) begin
         @(negedge clk);
         check_flag("halted after HALT", halted, 1'b1);
         check_addr("imem_addr while halted", imem_addr, exp_halt_pc);
      end
      #DRIVE_DELAY monitor_on = 1'b0;
      if (retires - retire_base < exp_dst.size()) begin
         $display("%s: only %0d of %0d expected retires appeared", name,
                  retires - retire_base, exp_dst.size());
         fails++;
      end
      check_flag("err seen", err_cycles != err_base, exp_err);
      fails += (wb_mismatches - wb_base) + (extra_retires - extra_base);
      fails += flag_mismatches - flag_base;
      fails += addr_mismatches - addr_base;
      tests_run++;
      if (fails == 0) begin
         $display("test %s: ok, %0d retires", name, retires - retire_base);
      end else begin
         $display("test %s: failed with %0d errors", name, fails);
         tests_failed++;
      end
   endtask

   task automatic test_alu();
      clear_program();
      emit_lbi_random(3'd1);
      emit_lbi_random(3'd2);
      emit_lbi_random(3'd3);
      emit_lbi_random(3'd4);
      emit(enc_r(OP_ADD, 3'd5, 3'd1, 3'd2));
      emit(enc_r(OP_SUB, 3'd6, 3'd3, 3'd4));
      emit(enc_r(OP_AND, 3'd7, 3'd1, 3'd3));
      emit(enc_r(OP_XOR, 3'd0, 3'd2, 3'd4));
      emit(enc_i6(OP_ADDI, 3'd5, 3'd6, 6'h1f));
      emit(enc_i6(OP_ADDI, 3'd6, 3'd7, 6'h20));
      emit({OP_HALT, 12'h000});
      run_program("alu", 8);
   endtask

   // sources at distance one, two and three from their producers
   task automatic test_deps();
      clear_program();
      emit(enc_i9(OP_LBI, 3'd1, 9'h123));
      emit(enc_i9(OP_LBI, 3'd2, 9'h045));
      emit(enc_r(OP_ADD, 3'd3, 3'd1, 3'd2));
      emit(enc_r(OP_SUB, 3'd4, 3'd3, 3'd1));
      emit(enc_i6(OP_ADDI, 3'd5, 3'd3, 6'h3e));
      emit(enc_r(OP_AND, 3'd6, 3'd3, 3'd5));
      emit(enc_r(OP_XOR, 3'd7, 3'd6, 3'd4));
      emit(enc_r(OP_ADD, 3'd1, 3'd7, 3'd5));
      emit(enc_i6(OP_ADDI, 3'd1, 3'd1, 6'h01));
      emit({OP_HALT, 12'h000});
      run_program("deps", 8);
   endtask

   task automatic test_mem();
      clear_program();
      emit(enc_i9(OP_LBI, 3'd1, 9'h010));
      emit(enc_i9(OP_LBI, 3'd2, 9'h0ab));
      emit(enc_i9(OP_LBI, 3'd3, 9'h1c5));
      emit(enc_i6(OP_ST, 3'd2, 3'd1, 6'h00));
      emit(enc_i6(OP_ST, 3'd3, 3'd1, 6'h04));
      emit(enc_i6(OP_LD, 3'd4, 3'd1, 6'h00));
      emit(enc_i6(OP_LD, 3'd5, 3'd1, 6'h04));
      // words never stored read back as zero
      emit(enc_i6(OP_LD, 3'd6, 3'd1, 6'h02));
      emit(enc_i6(OP_LD, 3'd7, 3'd1, 6'h3e));
      emit(enc_i6(OP_ADDI, 3'd1, 3'd1, 6'h02));
      emit(enc_i6(OP_ST, 3'd4, 3'd1, 6'h00));
      emit(enc_i6(OP_LD, 3'd0, 3'd1, 6'h00));
      emit({OP_HALT, 12'h000});
      run_program("mem", 8);
   endtask

   // LBI with 9'h0ee marks the shadows of taken branches
   task automatic test_branch();
      clear_program();
      emit(enc_i9(OP_LBI, 3'd1, 9'h000));
      emit(enc_i9(OP_LBI, 3'd2, 9'h005));
      emit(enc_i9(OP_BEQZ, 3'd1, 9'h002));
      emit(enc_i9(OP_LBI, 3'd3, 9'h0ee));
      emit(enc_i9(OP_LBI, 3'd4, 9'h0ee));
      emit(enc_i9(OP_BEQZ, 3'd2, 9'h001));
      emit(enc_i6(OP_ADDI, 3'd5, 3'd2, 6'h01));
      emit(enc_j(12'h003));
      emit(enc_i9(OP_LBI, 3'd6, 9'h0ee));
      emit(enc_i9(OP_LBI, 3'd7, 9'h0ee));
      emit(enc_j(12'h004));
      emit(enc_i6(OP_ADDI, 3'd0, 3'd0, 6'h01));
      emit(enc_j(12'hffd));
      emit(enc_i9(OP_LBI, 3'd3, 9'h0ee));
      emit(enc_i9(OP_LBI, 3'd4, 9'h0ee));
      emit(enc_r(OP_ADD, 3'd6, 3'd5, 3'd0));
      emit(enc_i9(OP_BEQZ, 3'd6, 9'h001));
      emit({OP_HALT, 12'h000});
      run_program("branch", 8);
   endtask

   task automatic test_halt();
      clear_program();
      emit(enc_i9(OP_LBI, 3'd1, 9'h011));
      emit({OP_HALT, 12'h000});
      emit(enc_i9(OP_LBI, 3'd2, 9'h022));
      emit(enc_i9(OP_LBI, 3'd3, 9'h033));
      emit(enc_i6(OP_ST, 3'd1, 3'd0, 6'h00));
      run_program("halt", 32);
   endtask

   task automatic test_illegal();
      clear_program();
      emit(enc_i9(OP_LBI, 3'd1, 9'h00f));
      emit({4'hc, 12'h5a5});
      emit(enc_i6(OP_ADDI, 3'd2, 3'd1, 6'h01));
      emit({4'hf, 12'hfff});
      emit(enc_r(OP_ADD, 3'd3, 3'd2, 3'd1));
      emit({OP_HALT, 12'h000});
      run_program("illegal", 8);
   endtask

   // backup limit that grows with each loaded program
   initial begin
      while ($time < budget) begin
         #(CLK_PERIOD);
      end
      $display("watchdog expired at %0d ns, a test is stuck", $time);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      clear_program();
      test_alu();
      test_deps();
      test_mem();
      test_branch();
      test_halt();
      test_illegal();
      $display("tests run %0d, failed %0d", tests_run, tests_failed);
      if (tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== proc.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch.sv
src/pipe_regs.sv
src/decode.sv
src/execute.sv
src/proc.sv
testbench/tb_clock.sv
testbench/proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds proc_tb with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/100ps \
   --top-module proc_tb -Mdir obj_dir -f proc.f

./obj_dir/Vproc_tb | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
